/* design/dcache_defs.svh */
/*
 * widths and depths for the data-cache miss controller
 * line, half-line and byte-enable sizes, tag and transaction id widths
 * and the default depth of the request queue
 */

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// byte address
`define DC_ADR_BITS 32

// cache line and bus word
`define DC_LINE_BITS 512
`define DC_HALF_BITS 256

// byte enables per line and per half
`define DC_LINE_BYTES 64
`define DC_HALF_BYTES 32

// line offset, top bit picks the half
`define DC_OFFSET_BITS 6

// core request tag and bus transaction id
`define DC_TAG_BITS 4
`define DC_TID_BITS 4

// request slots
`define DC_QUEUE_DEPTH 4

`endif

/* design/dcache_pkg.sv */
/*
 * types shared by the miss controller blocks
 * vector types for addresses, lines, halves, enables and ids
 * and the state encoding of the sequencer FSM
 */

`include "dcache_defs.svh"

package dcache_pkg;

	// ====================
	// vectors
	// ====================

	// byte address, line aligned for core requests
	typedef logic [`DC_ADR_BITS-1:0] adr_t;

	// full line and one bus word
	typedef logic [`DC_LINE_BITS-1:0] line_t;
	typedef logic [`DC_HALF_BITS-1:0] half_t;

	// byte enables
	typedef logic [`DC_LINE_BYTES-1:0] line_sel_t;
	typedef logic [`DC_HALF_BYTES-1:0] half_sel_t;

	// core tag and bus transaction id
	typedef logic [`DC_TAG_BITS-1:0] tag_t;
	typedef logic [`DC_TID_BITS-1:0] tid_t;

	// ====================
	// sequencer states
	// ====================

	typedef enum logic [2:0] {
		IDLE,
		DUMP,
		LOAD,
		FILL_WAIT,
		STORE,
		FINISH
	} seq_state_t;

endpackage

/* design/dcache_req_queue.sv */
/*
 * request queue of the miss controller
 * free slot search, duplicate tag rejection and busy level
 * acceptance-order ring that presents the oldest entry as head
 */

`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_req_queue #(
	parameter int DEPTH = `DC_QUEUE_DEPTH
) (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  req_valid_i,
	input  logic                  req_we_i,
	input  logic                  req_hit_i,
	input  dcache_pkg::tag_t      req_tag_i,
	input  dcache_pkg::adr_t      req_adr_i,
	input  dcache_pkg::adr_t      victim_adr_i,
	input  dcache_pkg::line_sel_t req_sel_i,
	input  dcache_pkg::line_t     req_dat_i,
	input  dcache_pkg::line_t     victim_dat_i,
	input  logic                  req_dirty_i,
	input  logic                  pop_i,
	output logic                  busy_o,
	output logic                  head_valid_o,
	output logic                  head_we_o,
	output logic                  head_hit_o,
	output logic                  head_dirty_o,
	output dcache_pkg::tag_t      head_tag_o,
	output dcache_pkg::adr_t      head_adr_o,
	output dcache_pkg::adr_t      head_victim_adr_o,
	output dcache_pkg::line_sel_t head_sel_o,
	output dcache_pkg::line_t     head_dat_o,
	output dcache_pkg::line_t     head_victim_dat_o
);
	import dcache_pkg::*;

	localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	// slot contents
	logic [DEPTH-1:0] valid_q;
	logic             we_q [DEPTH];
	logic             hit_q [DEPTH];
	logic             dirty_q [DEPTH];
	tag_t             tag_q [DEPTH];
	adr_t             adr_q [DEPTH];
	adr_t             vadr_q [DEPTH];
	line_sel_t        sel_q [DEPTH];
	line_t            dat_q [DEPTH];
	line_t            vdat_q [DEPTH];

	// ring of slot indices in acceptance order
	logic [IW-1:0] order_q [DEPTH];
	logic [IW-1:0] wr_ptr_q;
	logic [IW-1:0] rd_ptr_q;
	logic [CW-1:0] count_q;
	logic [CW-1:0] count_next;

	logic [IW-1:0] free_idx;
	logic [IW-1:0] head_idx;
	logic          dup_hit;
	logic          accept;

	function automatic logic [IW-1:0] ptr_inc(input logic [IW-1:0] p);
		ptr_inc = (p == IW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// ====================
	// slot search
	// ====================

	// lowest free slot, and tag match against every live entry
	// an entry popped this cycle is still live here
	always_comb begin
		free_idx = '0;
		dup_hit = 1'b0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (!valid_q[i])
				free_idx = IW'(i);
			if (valid_q[i] && tag_q[i] == req_tag_i)
				dup_hit = 1'b1;
		end
	end

	// busy low guarantees a free slot, rejected strobes just vanish
	assign accept = req_valid_i && !busy_o && !dup_hit;
	assign count_next = count_q + CW'(accept) - CW'(pop_i);

	// ====================
	// control state
	// ====================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= '0;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			busy_o <= 1'b0;
		end else begin
			// head leaves on pop
			if (pop_i) begin
				valid_q[head_idx] <= 1'b0;
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			end
			// new entry never lands on the head slot, which is still valid
			if (accept) begin
				valid_q[free_idx] <= 1'b1;
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			end
			count_q <= count_next;
			// level follows the fill one cycle later
			busy_o <= (count_next == CW'(DEPTH));
		end
	end

	// request payload and order ring
	always_ff @(posedge clk_i) begin
		if (accept) begin
			order_q[wr_ptr_q] <= free_idx;
			we_q[free_idx] <= req_we_i;
			hit_q[free_idx] <= req_hit_i;
			dirty_q[free_idx] <= req_dirty_i;
			tag_q[free_idx] <= req_tag_i;
			adr_q[free_idx] <= req_adr_i;
			vadr_q[free_idx] <= victim_adr_i;
			sel_q[free_idx] <= req_sel_i;
			dat_q[free_idx] <= req_dat_i;
			vdat_q[free_idx] <= victim_dat_i;
		end
	end

	// ====================
	// head
	// ====================

	assign head_idx = order_q[rd_ptr_q];
	assign head_valid_o = (count_q != '0);
	assign head_we_o = we_q[head_idx];
	assign head_hit_o = hit_q[head_idx];
	assign head_dirty_o = dirty_q[head_idx];
	assign head_tag_o = tag_q[head_idx];
	assign head_adr_o = adr_q[head_idx];
	assign head_victim_adr_o = vadr_q[head_idx];
	assign head_sel_o = sel_q[head_idx];
	assign head_dat_o = dat_q[head_idx];
	assign head_victim_dat_o = vdat_q[head_idx];

	// sequencer only retires an entry it was shown
	a_pop_has_head: assert property (@(posedge clk_i) disable iff (rst_i)
		pop_i |-> head_valid_o);

endmodule

/* design/dcache_seq.sv */
/*
 * sequencer FSM of the miss controller
 * victim writeback, line fill, write-through stores with empty-half skip
 * and the final ack, cache write and queue pop
 */

`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_seq (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  head_valid_i,
	input  logic                  head_we_i,
	input  logic                  head_hit_i,
	input  logic                  head_dirty_i,
	input  dcache_pkg::tag_t      head_tag_i,
	input  dcache_pkg::adr_t      head_adr_i,
	input  dcache_pkg::adr_t      head_victim_adr_i,
	input  dcache_pkg::line_sel_t head_sel_i,
	input  dcache_pkg::line_t     head_dat_i,
	input  dcache_pkg::line_t     head_victim_dat_i,
	input  logic                  issue_accept_i,
	input  logic                  fill_done_i,
	input  dcache_pkg::line_t     fill_line_i,
	output logic                  pop_o,
	output logic                  issue_valid_o,
	output logic                  issue_we_o,
	output dcache_pkg::adr_t      issue_adr_o,
	output dcache_pkg::half_sel_t issue_sel_o,
	output dcache_pkg::half_t     issue_dat_o,
	output logic                  ack_o,
	output dcache_pkg::tag_t      ack_tag_o,
	output dcache_pkg::line_t     ack_dat_o,
	output logic                  cache_wr_o,
	output dcache_pkg::adr_t      cache_adr_o,
	output dcache_pkg::line_sel_t cache_sel_o,
	output dcache_pkg::line_t     cache_dat_o
);
	import dcache_pkg::*;

	seq_state_t state_q;
	// which half is being issued
	logic       half_q;
	half_sel_t  cur_sel;
	logic       last_store;
	logic       miss;

	// half address: bit 5 is the half, low bits clear
	function automatic adr_t half_adr(input adr_t line_adr, input logic half);
		half_adr = {line_adr[`DC_ADR_BITS-1:`DC_OFFSET_BITS], half,
			{(`DC_OFFSET_BITS - 1){1'b0}}};
	endfunction

	assign miss = !head_we_i && !head_hit_i;

	// store enables of the current half
	assign cur_sel = head_sel_i[half_q * `DC_HALF_BYTES +: `DC_HALF_BYTES];
	// nothing left after this half
	assign last_store = half_q || ~|head_sel_i[`DC_LINE_BYTES-1:`DC_HALF_BYTES];

	// ====================
	// issue request
	// ====================

	always_comb begin
		issue_valid_o = 1'b0;
		issue_we_o = 1'b0;
		issue_adr_o = half_adr(head_adr_i, half_q);
		issue_sel_o = '1;
		issue_dat_o = '0;
		case (state_q)
			// victim halves, full enables
			DUMP: begin
				issue_valid_o = 1'b1;
				issue_we_o = 1'b1;
				issue_adr_o = half_adr(head_victim_adr_i, half_q);
				issue_dat_o = head_victim_dat_i[half_q * `DC_HALF_BITS +: `DC_HALF_BITS];
			end
			// fill loads carry no data
			LOAD: begin
				issue_valid_o = 1'b1;
			end
			// empty halves never reach the bus
			STORE: begin
				issue_valid_o = |cur_sel;
				issue_we_o = 1'b1;
				issue_sel_o = cur_sel;
				issue_dat_o = head_dat_i[half_q * `DC_HALF_BITS +: `DC_HALF_BITS];
			end
			default: begin
				issue_valid_o = 1'b0;
			end
		endcase
	end

	// ====================
	// state machine
	// ====================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= IDLE;
			half_q <= 1'b0;
			ack_o <= 1'b0;
			pop_o <= 1'b0;
			cache_wr_o <= 1'b0;
		end else begin
			// pulses
			ack_o <= 1'b0;
			pop_o <= 1'b0;
			cache_wr_o <= 1'b0;
			case (state_q)
				// head still shows the retiring entry during the pop cycle
				IDLE: begin
					if (head_valid_i && !pop_o) begin
						half_q <= 1'b0;
						if (head_we_i)
							state_q <= STORE;
						else if (head_hit_i)
							state_q <= FINISH;
						else if (head_dirty_i)
							state_q <= DUMP;
						else
							state_q <= LOAD;
					end
				end
				// both victim halves, then the fill
				DUMP: begin
					if (issue_accept_i) begin
						half_q <= ~half_q;
						if (half_q)
							state_q <= LOAD;
					end
				end
				LOAD: begin
					if (issue_accept_i) begin
						half_q <= ~half_q;
						if (half_q)
							state_q <= FILL_WAIT;
					end
				end
				FILL_WAIT: begin
					if (fill_done_i)
						state_q <= FINISH;
				end
				// advance on accept, or straight away past an empty half
				STORE: begin
					if (issue_accept_i || !issue_valid_o) begin
						half_q <= 1'b1;
						if (last_store)
							state_q <= FINISH;
					end
				end
				FINISH: begin
					ack_o <= 1'b1;
					pop_o <= 1'b1;
					// fill on read miss, update on store hit
					cache_wr_o <= miss || (head_we_i && head_hit_i);
					state_q <= IDLE;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// ack and cache write payload, captured while the head is still current
	always_ff @(posedge clk_i) begin
		if (state_q == FINISH) begin
			ack_tag_o <= head_tag_i;
			ack_dat_o <= miss ? fill_line_i : '0;
			cache_adr_o <= head_adr_i;
			cache_sel_o <= miss ? '1 : head_sel_i;
			cache_dat_o <= miss ? fill_line_i : head_dat_i;
		end
	end

	// a completed fill only ever arrives while the FSM waits for it
	a_fill_in_wait: assert property (@(posedge clk_i) disable iff (rst_i)
		fill_done_i |-> state_q == FILL_WAIT);

endmodule

/* design/dcache_bus_port.sv */
/*
 * bus side of the miss controller
 * one-deep request register with transaction id counter
 * tid tracking of outstanding loads and assembly of the filled line
 */

`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_bus_port (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  issue_valid_i,
	input  logic                  issue_we_i,
	input  dcache_pkg::adr_t      issue_adr_i,
	input  dcache_pkg::half_sel_t issue_sel_i,
	input  dcache_pkg::half_t     issue_dat_i,
	input  logic                  bus_full_i,
	input  logic                  bus_ack_i,
	input  dcache_pkg::tid_t      bus_rsp_tid_i,
	input  dcache_pkg::half_t     bus_rsp_dat_i,
	output logic                  issue_accept_o,
	output logic                  bus_cyc_o,
	output logic                  bus_we_o,
	output dcache_pkg::adr_t      bus_adr_o,
	output dcache_pkg::half_sel_t bus_sel_o,
	output dcache_pkg::half_t     bus_dat_o,
	output dcache_pkg::tid_t      bus_tid_o,
	output logic                  fill_done_o,
	output dcache_pkg::line_t     fill_line_o
);
	import dcache_pkg::*;

	// address bit that picks the half
	localparam int HB = `DC_OFFSET_BITS - 1;

	// next id to hand out, 1..15
	tid_t       tid_q;
	logic       take;
	// per half: load out on the bus, its tid, data arrived
	logic [1:0] pend_q;
	tid_t       pend_tid_q [2];
	logic [1:0] got_q;
	logic [1:0] got_next;
	logic [1:0] rsp_hit;
	line_t      line_q;

	// bus takes the held request
	assign take = bus_cyc_o && !bus_full_i;
	// register is empty or drains this cycle
	assign issue_accept_o = issue_valid_i && (!bus_cyc_o || !bus_full_i);

	// match a response against each pending half, stray tids fall through
	always_comb begin
		for (int h = 0; h < 2; h++)
			rsp_hit[h] = bus_ack_i && pend_q[h] && (pend_tid_q[h] == bus_rsp_tid_i);
	end

	assign got_next = got_q | rsp_hit;
	assign fill_line_o = line_q;

	// ====================
	// control
	// ====================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bus_cyc_o <= 1'b0;
			tid_q <= tid_t'(1);
			pend_q <= '0;
			got_q <= '0;
			fill_done_o <= 1'b0;
		end else begin
			if (issue_accept_o) begin
				bus_cyc_o <= 1'b1;
				// skip 0 on wrap
				tid_q <= (tid_q == '1) ? tid_t'(1) : tid_q + 1'b1;
			end else if (take) begin
				bus_cyc_o <= 1'b0;
			end
			// only loads wait for a response
			for (int h = 0; h < 2; h++) begin
				if (take && !bus_we_o && bus_adr_o[HB] == h[0])
					pend_q[h] <= 1'b1;
				else if (rsp_hit[h])
					pend_q[h] <= 1'b0;
			end
			// one pulse per completed line
			fill_done_o <= (got_next == 2'b11);
			got_q <= (got_next == 2'b11) ? 2'b00 : got_next;
		end
	end

	// ====================
	// payload
	// ====================

	always_ff @(posedge clk_i) begin
		// held unchanged while the bus is full
		if (issue_accept_o) begin
			bus_we_o <= issue_we_i;
			bus_adr_o <= issue_adr_i;
			bus_sel_o <= issue_sel_i;
			bus_dat_o <= issue_dat_i;
			bus_tid_o <= tid_q;
		end
		if (take && !bus_we_o)
			pend_tid_q[bus_adr_o[HB]] <= bus_tid_o;
		// drop each half into its place in the line
		for (int h = 0; h < 2; h++) begin
			if (rsp_hit[h])
				line_q[h * `DC_HALF_BITS +: `DC_HALF_BITS] <= bus_rsp_dat_i;
		end
	end

	// a new load never lands on a half still waiting for its data
	a_load_half_free: assert property (@(posedge clk_i) disable iff (rst_i)
		take && !bus_we_o |-> !pend_q[bus_adr_o[HB]]);

endmodule

/* design/dcache_ctrl.sv */
/*
 * data-cache miss controller top
 * request queue, sequencer and bus port
 */

`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                  clk_i,
	input  logic                  rst_i,
	// core requests
	input  logic                  req_valid_i,
	input  dcache_pkg::tag_t      req_tag_i,
	input  logic                  req_we_i,
	input  dcache_pkg::adr_t      req_adr_i,
	input  dcache_pkg::line_sel_t req_sel_i,
	input  dcache_pkg::line_t     req_dat_i,
	input  logic                  req_hit_i,
	input  logic                  req_dirty_i,
	input  dcache_pkg::adr_t      victim_adr_i,
	input  dcache_pkg::line_t     victim_dat_i,
	output logic                  busy_o,
	// acks to the core
	output logic                  ack_o,
	output dcache_pkg::tag_t      ack_tag_o,
	output dcache_pkg::line_t     ack_dat_o,
	// cache array write
	output logic                  cache_wr_o,
	output dcache_pkg::adr_t      cache_adr_o,
	output dcache_pkg::line_sel_t cache_sel_o,
	output dcache_pkg::line_t     cache_dat_o,
	// memory bus
	output logic                  bus_cyc_o,
	output logic                  bus_we_o,
	output dcache_pkg::adr_t      bus_adr_o,
	output dcache_pkg::half_sel_t bus_sel_o,
	output dcache_pkg::half_t     bus_dat_o,
	output dcache_pkg::tid_t      bus_tid_o,
	input  logic                  bus_full_i,
	input  logic                  bus_ack_i,
	input  dcache_pkg::tid_t      bus_rsp_tid_i,
	input  dcache_pkg::half_t     bus_rsp_dat_i
);
	import dcache_pkg::*;

	// queue head
	logic      head_valid;
	logic      head_we;
	logic      head_hit;
	logic      head_dirty;
	tag_t      head_tag;
	adr_t      head_adr;
	adr_t      head_victim_adr;
	line_sel_t head_sel;
	line_t     head_dat;
	line_t     head_victim_dat;
	logic      pop;

	// sequencer to bus port
	logic      issue_valid;
	logic      issue_we;
	adr_t      issue_adr;
	half_sel_t issue_sel;
	half_t     issue_dat;
	logic      issue_accept;
	logic      fill_done;
	line_t     fill_line;

	dcache_req_queue i_queue (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.req_valid_i       (req_valid_i),
		.req_we_i          (req_we_i),
		.req_hit_i         (req_hit_i),
		.req_tag_i         (req_tag_i),
		.req_adr_i         (req_adr_i),
		.victim_adr_i      (victim_adr_i),
		.req_sel_i         (req_sel_i),
		.req_dat_i         (req_dat_i),
		.victim_dat_i      (victim_dat_i),
		.req_dirty_i       (req_dirty_i),
		.pop_i             (pop),
		.busy_o            (busy_o),
		.head_valid_o      (head_valid),
		.head_we_o         (head_we),
		.head_hit_o        (head_hit),
		.head_dirty_o      (head_dirty),
		.head_tag_o        (head_tag),
		.head_adr_o        (head_adr),
		.head_victim_adr_o (head_victim_adr),
		.head_sel_o        (head_sel),
		.head_dat_o        (head_dat),
		.head_victim_dat_o (head_victim_dat)
	);

	dcache_seq i_seq (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.head_valid_i      (head_valid),
		.head_we_i         (head_we),
		.head_hit_i        (head_hit),
		.head_dirty_i      (head_dirty),
		.head_tag_i        (head_tag),
		.head_adr_i        (head_adr),
		.head_victim_adr_i (head_victim_adr),
		.head_sel_i        (head_sel),
		.head_dat_i        (head_dat),
		.head_victim_dat_i (head_victim_dat),
		.issue_accept_i    (issue_accept),
		.fill_done_i       (fill_done),
		.fill_line_i       (fill_line),
		.pop_o             (pop),
		.issue_valid_o     (issue_valid),
		.issue_we_o        (issue_we),
		.issue_adr_o       (issue_adr),
		.issue_sel_o       (issue_sel),
		.issue_dat_o       (issue_dat),
		.ack_o             (ack_o),
		.ack_tag_o         (ack_tag_o),
		.ack_dat_o         (ack_dat_o),
		.cache_wr_o        (cache_wr_o),
		.cache_adr_o       (cache_adr_o),
		.cache_sel_o       (cache_sel_o),
		.cache_dat_o       (cache_dat_o)
	);

	dcache_bus_port i_bus (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.issue_valid_i  (issue_valid),
		.issue_we_i     (issue_we),
		.issue_adr_i    (issue_adr),
		.issue_sel_i    (issue_sel),
		.issue_dat_i    (issue_dat),
		.bus_full_i     (bus_full_i),
		.bus_ack_i      (bus_ack_i),
		.bus_rsp_tid_i  (bus_rsp_tid_i),
		.bus_rsp_dat_i  (bus_rsp_dat_i),
		.issue_accept_o (issue_accept),
		.bus_cyc_o      (bus_cyc_o),
		.bus_we_o       (bus_we_o),
		.bus_adr_o      (bus_adr_o),
		.bus_sel_o      (bus_sel_o),
		.bus_dat_o      (bus_dat_o),
		.bus_tid_o      (bus_tid_o),
		.fill_done_o    (fill_done),
		.fill_line_o    (fill_line)
	);

endmodule

/* dv/tb_dcache_checks.svh */
/*
 * compare tasks of the miss controller testbench
 * sparse memory models behind the bus and in request order
 * reference model that turns each accepted request into expected results
 */

`ifndef TB_DCACHE_CHECKS_SVH
`define TB_DCACHE_CHECKS_SVH

int checks;
int errors;

// memory seen by the bus responder, and the in-order reference copy
half_t bus_mem [adr_t];
half_t ref_mem [adr_t];

// expected bus transactions in issue order
logic      xq_we [$];
adr_t      xq_adr [$];
half_sel_t xq_sel [$];
half_t     xq_dat [$];

// expected acks in acceptance order
tag_t      aq_tag [$];
line_t     aq_ack_dat [$];
logic      aq_cwr [$];
adr_t      aq_cadr [$];
line_sel_t aq_csel [$];
line_t     aq_cdat [$];

// ====================
// compare tasks
// ====================

task automatic check_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
	end
endtask

task automatic check_tag(input string name, input tag_t got, input tag_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_tid(input string name, input tid_t got, input tid_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_adr(input string name, input adr_t got, input adr_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_line(input string name, input line_t got, input line_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_sel(input string name, input line_sel_t got, input line_sel_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_half(input string name, input half_t got, input half_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_half_sel(input string name, input half_sel_t got, input half_sel_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

// ====================
// memory model
// ====================

// untouched memory, every word differs with the whole address
function automatic half_t fill_pattern(input adr_t a);
	half_t v;
	for (int i = 0; i < 8; i++)
		v[i*32 +: 32] = a ^ (32'h9e3779b9 * 32'(i + 1)) ^ {a[15:0], a[31:16]};
	return v;
endfunction

function automatic half_t mem_get(input bit use_ref, input adr_t a);
	if (use_ref)
		return ref_mem.exists(a) ? ref_mem[a] : fill_pattern(a);
	return bus_mem.exists(a) ? bus_mem[a] : fill_pattern(a);
endfunction

// byte-enabled write into one of the two models
task automatic mem_put(input bit use_ref, input adr_t a, input half_sel_t sel, input half_t d);
	half_t v;
	v = mem_get(use_ref, a);
	for (int b = 0; b < `DC_HALF_BYTES; b++) begin
		if (sel[b])
			v[b*8 +: 8] = d[b*8 +: 8];
	end
	if (use_ref)
		ref_mem[a] = v;
	else
		bus_mem[a] = v;
endtask

function automatic adr_t half_adr(input adr_t line_adr, input logic h);
	return {line_adr[31:6], h, 5'b0};
endfunction

task automatic expect_txn(input logic we, input adr_t a, input half_sel_t sel, input half_t d);
	xq_we.push_back(we);
	xq_adr.push_back(a);
	xq_sel.push_back(sel);
	xq_dat.push_back(d);
endtask

// requests retire in acceptance order, so the reference is updated right here
task automatic model_accept(input tag_t tag, input logic we, input logic hit,
	input logic dirty, input adr_t adr, input line_sel_t sel, input line_t dat,
	input adr_t vadr, input line_t vdat);
	line_t     fill;
	logic      miss;
	half_sel_t hs;
	miss = !we && !hit;
	fill = '0;
	// victim goes out before the fill
	for (int h = 0; h < 2; h++) begin
		if (miss && dirty) begin
			expect_txn(1'b1, half_adr(vadr, h[0]), '1, vdat[h*256 +: 256]);
			mem_put(1'b1, half_adr(vadr, h[0]), '1, vdat[h*256 +: 256]);
		end
	end
	for (int h = 0; h < 2; h++) begin
		if (miss) begin
			expect_txn(1'b0, half_adr(adr, h[0]), '1, '0);
			fill[h*256 +: 256] = mem_get(1'b1, half_adr(adr, h[0]));
		end
		hs = sel[h*32 +: 32];
		// empty halves stay off the bus
		if (we && |hs) begin
			expect_txn(1'b1, half_adr(adr, h[0]), hs, dat[h*256 +: 256]);
			mem_put(1'b1, half_adr(adr, h[0]), hs, dat[h*256 +: 256]);
		end
	end
	aq_tag.push_back(tag);
	aq_ack_dat.push_back(fill);
	aq_cwr.push_back(miss || (we && hit));
	aq_cadr.push_back(adr);
	aq_csel.push_back(miss ? '1 : sel);
	aq_cdat.push_back(miss ? fill : dat);
endtask

`endif

/* dv/tb_dcache.sv */
/*
 * testbench of the data-cache miss controller
 * clock, reset, random requests, bus responder with back-pressure
 * and scoreboard of bus transactions and acks
 */

`timescale 1ns/1ps

`include "dcache_defs.svh"

module tb_dcache;
	import dcache_pkg::*;

	// 200 cycles per request over all tests
	localparam int LIMIT = 200 * (40 + 15 + 15 + 25 + 30);

	logic clk_i;
	logic rst_i;
	logic req_valid_i, req_we_i, req_hit_i, req_dirty_i;
	tag_t req_tag_i;
	adr_t req_adr_i, victim_adr_i;
	line_sel_t req_sel_i;
	line_t req_dat_i, victim_dat_i;
	logic busy_o, ack_o, cache_wr_o;
	tag_t ack_tag_o;
	line_t ack_dat_o, cache_dat_o;
	adr_t cache_adr_o, bus_adr_o;
	line_sel_t cache_sel_o;
	logic bus_cyc_o, bus_we_o, bus_full_i, bus_ack_i;
	half_sel_t bus_sel_o;
	half_t bus_dat_o, bus_rsp_dat_i;
	tid_t bus_tid_o, bus_rsp_tid_i;

	integer seed;
	int cycle;
	int tests;
	int to_send;
	int mode;
	int full_pct;
	int accepted;
	int rejected;

	// queue full as the model counts it, and the next bus id
	logic exp_busy;
	tid_t exp_tid;

	// bus outputs one cycle back, for the hold check
	logic prev_cyc, prev_full, prev_we;
	adr_t prev_adr;
	half_sel_t prev_sel;
	half_t prev_dat;
	tid_t prev_tid;

	// pending load responses
	tid_t rs_tid [$];
	adr_t rs_adr [$];
	int rs_due [$];

	`include "tb_dcache_checks.svh"

	dcache_ctrl i_dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	function automatic int urand(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic line_t rand_line();
		line_t v;
		for (int i = 0; i < 16; i++)
			v[i*32 +: 32] = $random(seed);
		return v;
	endfunction

	// empty, full or scattered enables
	function automatic half_sel_t rand_half_sel();
		int k;
		k = urand(3);
		if (k == 0)
			return '0;
		if (k == 1)
			return '1;
		return half_sel_t'($random(seed));
	endfunction

	// tag of a request that has not been acked yet
	function automatic logic tag_live(input tag_t t);
		foreach (aq_tag[i]) begin
			if (aq_tag[i] == t)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic drive_request();
		logic we, hit, dirty;
		tag_t tag;
		we = urand(2) == 1;
		hit = urand(2) == 1;
		dirty = urand(2) == 1;
		case (mode)
			1: {we, hit, dirty} = 3'b000;
			2: {we, hit, dirty} = 3'b001;
			3: we = 1'b1;
			default: ;
		endcase
		// some tags are copied from live entries on purpose
		if (mode == 0 && aq_tag.size() > 0 && urand(4) == 0)
			tag = aq_tag[urand(aq_tag.size())];
		else
			tag = tag_t'(urand(16));
		req_valid_i <= 1'b1;
		req_tag_i <= tag;
		req_we_i <= we;
		req_hit_i <= hit;
		req_dirty_i <= dirty;
		req_adr_i <= adr_t'(32'h0001_0000 + 32'(urand(8)) * 32'd64);
		req_sel_i <= {rand_half_sel(), rand_half_sel()};
		req_dat_i <= rand_line();
		victim_adr_i <= adr_t'(32'h0001_0000 + 32'(urand(8)) * 32'd64);
		victim_dat_i <= rand_line();
	endtask

	// ====================
	// scoreboard and drive
	// ====================

	always @(posedge clk_i) begin
		cycle++;
		if (!rst_i) begin
			// nothing moves while the bus is full
			if (prev_cyc && prev_full) begin
				check_bit("bus_cyc_o", bus_cyc_o, prev_cyc);
				check_bit("bus_we_o", bus_we_o, prev_we);
				check_adr("bus_adr_o", bus_adr_o, prev_adr);
				check_half_sel("bus_sel_o", bus_sel_o, prev_sel);
				check_half("bus_dat_o", bus_dat_o, prev_dat);
				check_tid("bus_tid_o", bus_tid_o, prev_tid);
			end
			// every slot holds an entry that is not acked yet
			exp_busy = aq_tag.size() == `DC_QUEUE_DEPTH;
			check_bit("busy_o", busy_o, exp_busy);
			// an entry acked in this cycle still blocks its tag
			if (req_valid_i) begin
				if (!exp_busy && !tag_live(req_tag_i)) begin
					accepted++;
					model_accept(req_tag_i, req_we_i, req_hit_i, req_dirty_i, req_adr_i,
						req_sel_i, req_dat_i, victim_adr_i, victim_dat_i);
				end else begin
					rejected++;
				end
			end
			if (ack_o) begin
				if (aq_tag.size() == 0) begin
					errors++;
					$display("ack at %0t with no request outstanding", $time);
				end else begin
					check_tag("ack_tag_o", ack_tag_o, aq_tag.pop_front());
					check_line("ack_dat_o", ack_dat_o, aq_ack_dat.pop_front());
					check_bit("cache_wr_o", cache_wr_o, aq_cwr[0]);
					if (aq_cwr.pop_front()) begin
						check_adr("cache_adr_o", cache_adr_o, aq_cadr[0]);
						check_sel("cache_sel_o", cache_sel_o, aq_csel[0]);
						check_line("cache_dat_o", cache_dat_o, aq_cdat[0]);
					end
					void'(aq_cadr.pop_front());
					void'(aq_csel.pop_front());
					void'(aq_cdat.pop_front());
				end
			end else if (cache_wr_o) begin
				errors++;
				$display("cache write at %0t without an ack", $time);
			end
			// transaction taken by the bus
			if (bus_cyc_o && !bus_full_i) begin
				checks++;
				if (bus_tid_o == '0) begin
					errors++;
					$display("bus transaction at %0t carries transaction id zero", $time);
				end
				check_tid("bus_tid_o", bus_tid_o, exp_tid);
				// ids run 1 to 15, then start over at 1
				exp_tid = (exp_tid == 4'hf) ? tid_t'(1) : exp_tid + 1'b1;
				if (xq_we.size() == 0) begin
					errors++;
					$display("bus transaction at %0t that no request needs", $time);
				end else begin
					check_bit("bus_we_o", bus_we_o, xq_we[0]);
					check_adr("bus_adr_o", bus_adr_o, xq_adr.pop_front());
					if (xq_we.pop_front()) begin
						check_half_sel("bus_sel_o", bus_sel_o, xq_sel[0]);
						check_half("bus_dat_o", bus_dat_o, xq_dat[0]);
					end
					void'(xq_sel.pop_front());
					void'(xq_dat.pop_front());
				end
				if (bus_we_o) begin
					mem_put(1'b0, bus_adr_o, bus_sel_o, bus_dat_o);
				end else begin
					rs_tid.push_back(bus_tid_o);
					rs_adr.push_back(bus_adr_o);
					rs_due.push_back(cycle + 1 + urand(6));
				end
			end
		end
		prev_cyc = bus_cyc_o && !rst_i;
		prev_full = bus_full_i;
		prev_we = bus_we_o;
		prev_adr = bus_adr_o;
		prev_sel = bus_sel_o;
		prev_dat = bus_dat_o;
		prev_tid = bus_tid_o;

		// responder, in load order after a random delay
		bus_full_i <= urand(100) < full_pct;
		bus_ack_i <= 1'b0;
		if (rs_tid.size() > 0 && cycle >= rs_due[0]) begin
			bus_ack_i <= 1'b1;
			bus_rsp_tid_i <= rs_tid.pop_front();
			bus_rsp_dat_i <= mem_get(1'b0, rs_adr.pop_front());
			void'(rs_due.pop_front());
		end
		req_valid_i <= 1'b0;
		if (!rst_i && to_send > 0 && !busy_o && urand(2) == 1) begin
			to_send--;
			drive_request();
		end
	end

	task automatic run_test(input string name, input int kind, input int n, input int pct);
		int err0;
		err0 = errors;
		accepted = 0;
		rejected = 0;
		mode = kind;
		full_pct = pct;
		to_send = n;
		@(posedge clk_i);
		#1;
		while (to_send > 0 || req_valid_i || aq_tag.size() > 0 || xq_we.size() > 0) begin
			@(posedge clk_i);
			#1;
		end
		tests++;
		$display("test %s: %0d accepted, %0d rejected, %0d errors", name, accepted, rejected,
			errors - err0);
	endtask

	// run ends here when requests stop completing
	initial begin
		while (cycle < LIMIT)
			@(posedge clk_i);
		$display("timeout after %0d cycles with requests still pending", cycle);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed = 32'hc82;
		exp_tid = tid_t'(1);
		rst_i <= 1'b1;
		req_valid_i <= 1'b0;
		req_tag_i <= '0;
		req_we_i <= 1'b0;
		req_hit_i <= 1'b0;
		req_dirty_i <= 1'b0;
		req_adr_i <= '0;
		req_sel_i <= '0;
		req_dat_i <= '0;
		victim_adr_i <= '0;
		victim_dat_i <= '0;
		bus_full_i <= 1'b0;
		bus_ack_i <= 1'b0;
		bus_rsp_tid_i <= '0;
		bus_rsp_dat_i <= '0;
		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;
		#1;
		check_bit("bus_cyc_o", bus_cyc_o, 1'b0);
		check_bit("ack_o", ack_o, 1'b0);
		check_bit("cache_wr_o", cache_wr_o, 1'b0);
		check_bit("busy_o", busy_o, 1'b0);
		tests++;
		$display("test reset: %0d errors", errors);
		run_test("ordering", 0, 40, 20);
		run_test("read_miss", 1, 15, 20);
		run_test("dirty_writeback", 2, 15, 20);
		run_test("store", 3, 25, 20);
		run_test("back_pressure", 4, 30, 70);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+design
+incdir+dv
design/dcache_pkg.sv
design/dcache_req_queue.sv
design/dcache_seq.sv
design/dcache_bus_port.sv
design/dcache_ctrl.sv
dv/tb_dcache.sv

/* run.sh */
#!/bin/bash
# build and run the miss controller testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_dcache -o tb_dcache \
	&& ./obj_dir/tb_dcache > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -q "Simulation passed" sim.log && echo "PASS" \
	|| { echo "FAIL"; exit 1; }
